// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_wallace_mult
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Testbench passed
VFLAGS ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh test/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+hdl
hdl/wallace_pkg.sv
hdl/pp_array.sv
hdl/csa_layer.sv
hdl/final_adder.sv
hdl/result_buffer.sv
hdl/wallace_mult.sv
test/tb_wallace_mult.sv

// File: hdl/csa_layer.sv
module csa_layer #(
	parameter int ROWS_IN = 16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  wallace_pkg::pp_row_t in_rows [ROWS_IN],
	output logic                 out_valid,
	output wallace_pkg::pp_row_t out_rows [ROWS_IN/2]
);

	localparam int ROW_W = $bits(wallace_pkg::pp_row_t);
	localparam int GROUPS = ROWS_IN / 4;

	wallace_pkg::pp_row_t comp_rows [ROWS_IN/2];

	// each group of four rows becomes a sum row and a carry row
	for (genvar g = 0; g < GROUPS; g++) begin : g_group
		wallace_pkg::pp_row_t r0;
		wallace_pkg::pp_row_t r1;
		wallace_pkg::pp_row_t r2;
		wallace_pkg::pp_row_t r3;
		wallace_pkg::pp_row_t sum_row;
		wallace_pkg::pp_row_t carry_row;
		// first full adder carry, enters the column above
		logic [ROW_W-1:0] mid_carry;

		assign r0 = in_rows[4*g];
		assign r1 = in_rows[4*g+1];
		assign r2 = in_rows[4*g+2];
		assign r3 = in_rows[4*g+3];
		assign mid_carry[0] = 1'b0;
		assign carry_row[0] = 1'b0;

		// 4:2 cell per column, two chained full adders
		for (genvar j = 0; j < ROW_W; j++) begin : g_col
			logic fa_sum;

			assign fa_sum = r0[j] ^ r1[j] ^ r2[j];
			assign sum_row[j] = fa_sum ^ r3[j] ^ mid_carry[j];

			// carries out of the top column lie above the product
			if (j < ROW_W - 1) begin : g_carry
				assign mid_carry[j+1] = (r0[j] & r1[j]) | (r0[j] & r2[j]) |
					(r1[j] & r2[j]);
				assign carry_row[j+1] = (fa_sum & r3[j]) | (fa_sum & mid_carry[j]) |
					(r3[j] & mid_carry[j]);
			end
		end

		assign comp_rows[2*g] = sum_row;
		assign comp_rows[2*g+1] = carry_row;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_rows <= comp_rows;
		end
	end

endmodule

// File: hdl/final_adder.sv
module final_adder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  wallace_pkg::pp_row_t  in_rows [2],
	output logic                  out_valid,
	output wallace_pkg::product_t product
);

	wallace_pkg::product_t sum;

	// carry-propagate add of the last sum and carry rows
	assign sum = in_rows[0] + in_rows[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			product <= sum;
		end
	end

endmodule

// File: hdl/pp_array.sv
`include "wallace_macros.svh"

module pp_array (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  wallace_pkg::operand_t a,
	input  wallace_pkg::operand_t b,
	output logic                 pp_valid,
	output wallace_pkg::pp_row_t pp_rows [`WALLACE_OPERAND_W]
);

	wallace_pkg::pp_row_t rows [`WALLACE_OPERAND_W];

	// row i is a gated by b[i], moved up to weight 2**i
	always_comb begin
		for (int i = 0; i < `WALLACE_OPERAND_W; i++) begin
			rows[i] = wallace_pkg::pp_row_t'(a & {`WALLACE_OPERAND_W{b[i]}}) << i;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pp_valid <= 1'b0;
		end else begin
			pp_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			pp_rows <= rows;
		end
	end

endmodule

// File: hdl/result_buffer.sv
`include "wallace_macros.svh"

module result_buffer #(
	parameter int DEPTH = `WALLACE_CREDITS
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  push,
	input  wallace_pkg::product_t push_data,
	input  logic                  out_credit,
	output logic                  out_valid,
	output wallace_pkg::product_t product,
	output logic                  in_credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	wallace_pkg::product_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	wallace_pkg::credit_cnt_t count;
	// credits held toward downstream
	wallace_pkg::credit_cnt_t out_cnt;
	logic pop;

	// one result leaves per cycle while data and a credit are there
	assign pop = (count != '0) && (out_cnt != '0);
	assign out_valid = pop;
	assign in_credit = pop;
	assign product = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// returned credits and spent credits may land in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_cnt <= wallace_pkg::credit_cnt_t'(`WALLACE_OUT_CREDITS);
		end else begin
			case ({out_credit, pop})
				2'b10: out_cnt <= out_cnt + 1'b1;
				2'b01: out_cnt <= out_cnt - 1'b1;
				default: out_cnt <= out_cnt;
			endcase
		end
	end

endmodule

// File: hdl/wallace_macros.svh
`ifndef WALLACE_MACROS_SVH
`define WALLACE_MACROS_SVH

// operand width
`define WALLACE_OPERAND_W 16

// product and aligned row width
`define WALLACE_PRODUCT_W 32

// result buffer depth and upstream credits after reset
`define WALLACE_CREDITS 4

// credits toward downstream after reset
`define WALLACE_OUT_CREDITS 2

`endif

// File: hdl/wallace_mult.sv
`include "wallace_macros.svh"

module wallace_mult (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  wallace_pkg::operand_t a,
	input  wallace_pkg::operand_t b,
	output logic                  in_credit,
	output logic                  out_valid,
	output wallace_pkg::product_t product,
	input  logic                  out_credit
);

	localparam int ROWS = `WALLACE_OPERAND_W;

	logic pp_valid;
	wallace_pkg::pp_row_t pp_rows [ROWS];

	logic l1_valid;
	wallace_pkg::pp_row_t l1_rows [ROWS/2];

	logic l2_valid;
	wallace_pkg::pp_row_t l2_rows [ROWS/4];

	logic l3_valid;
	wallace_pkg::pp_row_t l3_rows [ROWS/8];

	logic sum_valid;
	wallace_pkg::product_t sum_product;

	pp_array u_pp_array (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.a        (a),
		.b        (b),
		.pp_valid (pp_valid),
		.pp_rows  (pp_rows)
	);

	// 16 rows down to 2 over three layers
	csa_layer #(.ROWS_IN(ROWS)) u_csa_l1 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (pp_valid),
		.in_rows   (pp_rows),
		.out_valid (l1_valid),
		.out_rows  (l1_rows)
	);

	csa_layer #(.ROWS_IN(ROWS/2)) u_csa_l2 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (l1_valid),
		.in_rows   (l1_rows),
		.out_valid (l2_valid),
		.out_rows  (l2_rows)
	);

	csa_layer #(.ROWS_IN(ROWS/4)) u_csa_l3 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (l2_valid),
		.in_rows   (l2_rows),
		.out_valid (l3_valid),
		.out_rows  (l3_rows)
	);

	final_adder u_final_adder (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (l3_valid),
		.in_rows   (l3_rows),
		.out_valid (sum_valid),
		.product   (sum_product)
	);

	result_buffer #(.DEPTH(`WALLACE_CREDITS)) u_result_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (sum_valid),
		.push_data  (sum_product),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.product    (product),
		.in_credit  (in_credit)
	);

endmodule

// File: hdl/wallace_pkg.sv
`include "wallace_macros.svh"

package wallace_pkg;

	// one multiplier operand
	typedef logic [`WALLACE_OPERAND_W-1:0] operand_t;

	// full unsigned product
	typedef logic [`WALLACE_PRODUCT_W-1:0] product_t;

	// partial-product or compressed row, bit j has weight 2**j
	typedef logic [`WALLACE_PRODUCT_W-1:0] pp_row_t;

	// credit or occupancy count
	typedef logic [$clog2(`WALLACE_CREDITS + 1)-1:0] credit_cnt_t;

endpackage

// File: test/tb_wallace_mult.sv
`include "wallace_macros.svh"

module tb_wallace_mult;

	localparam int TIMEOUT = 1000;

	logic clk;
	logic rst_n;
	logic in_valid;
	wallace_pkg::operand_t a;
	wallace_pkg::operand_t b;
	logic in_credit;
	logic out_valid;
	wallace_pkg::product_t product;
	logic out_credit;

	int errors;
	// credits upstream may still spend
	int in_credits;
	// results received downstream and not yet paid back
	int pending;
	int out_count;
	int credit_pulses;
	int return_pct;
	bit auto_credit;
	wallace_pkg::product_t exp_q [$];

	wallace_mult dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.a          (a),
		.b          (b),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.product    (product),
		.out_credit (out_credit)
	);

	always #4 clk = ~clk;

	// downstream receiver, sampled mid cycle
	always @(negedge clk) begin : monitor
		wallace_pkg::product_t expected;
		if (rst_n === 1'b1) begin
			if (out_valid) begin
				out_count++;
				pending++;
				assert (exp_q.size() > 0) else begin
					errors++;
					$display("t=%0t: a result appeared with no product outstanding", $time);
				end
				if (exp_q.size() > 0) begin
					expected = exp_q.pop_front();
					assert (product === expected) else begin
						errors++;
						$display("ERR t=%0t product expected %h actual %h",
							$time, expected, product);
					end
				end
			end
			if (in_credit) begin
				credit_pulses++;
				in_credits++;
				assert (in_credits <= `WALLACE_CREDITS) else begin
					errors++;
					$display("t=%0t: upstream holds more credits than the buffer depth", $time);
				end
			end
		end
	end

	// downstream pays back credits for received results
	always @(posedge clk) begin
		#1;
		if (auto_credit) begin
			if (pending > 0 && ($urandom % 100) < return_pct) begin
				out_credit = 1'b1;
				pending--;
			end else begin
				out_credit = 1'b0;
			end
		end
	end

	task automatic send_op(input wallace_pkg::operand_t x, input wallace_pkg::operand_t y);
		int t;
		t = 0;
		while (in_credits == 0 && t < TIMEOUT) begin
			in_valid = 1'b0;
			@(posedge clk);
			#1;
			t++;
		end
		assert (in_credits > 0) else begin
			errors++;
			$display("t=%0t: timeout waiting for an input credit", $time);
		end
		if (in_credits > 0) begin
			in_valid = 1'b1;
			a = x;
			b = y;
			in_credits--;
			exp_q.push_back(wallace_pkg::product_t'(x) * wallace_pkg::product_t'(y));
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while ((exp_q.size() != 0 || pending != 0) && t < TIMEOUT) begin
			@(posedge clk);
			#1;
			t++;
		end
		assert (exp_q.size() == 0 && pending == 0) else begin
			errors++;
			$display("t=%0t: timeout waiting for results to drain", $time);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic return_credit();
		out_credit = 1'b1;
		pending--;
		@(posedge clk);
		#1;
		out_credit = 1'b0;
	endtask

	task automatic check_reset();
		rst_n = 1'b0;
		repeat (3) begin
			@(posedge clk);
			#1;
			assert (out_valid === 1'b0 && in_credit === 1'b0) else begin
				errors++;
				$display("t=%0t: out_valid or in_credit high during reset", $time);
			end
		end
		rst_n = 1'b1;
		repeat (3) begin
			@(posedge clk);
			#1;
			assert (out_valid === 1'b0 && in_credit === 1'b0) else begin
				errors++;
				$display("t=%0t: out_valid or in_credit high after reset", $time);
			end
		end
	endtask

	task automatic corner_products();
		wallace_pkg::operand_t ca [12];
		wallace_pkg::operand_t cb [12];
		int lat;
		ca = '{16'h0000, 16'h0001, 16'h1234, 16'hffff, 16'hffff, 16'h8000,
			16'h0001, 16'h0100, 16'h8000, 16'h0004, 16'h0001, 16'h4000};
		cb = '{16'h0000, 16'hbeef, 16'h0001, 16'hffff, 16'h0001, 16'h8000,
			16'h0001, 16'h0020, 16'h0001, 16'h0400, 16'h8000, 16'h0002};
		for (int i = 0; i < 12; i++) begin
			send_op(ca[i], cb[i]);
			// edges after the accepting one
			lat = 0;
			@(negedge clk);
			while (!out_valid && lat < 20) begin
				lat++;
				@(negedge clk);
			end
			assert (lat == 5) else begin
				errors++;
				$display("ERR t=%0t out_valid latency expected 5 actual %0d", $time, lat);
			end
			wait_drain();
		end
	endtask

	task automatic random_stream();
		int base;
		base = out_count;
		return_pct = 100;
		for (int i = 0; i < 200; i++) begin
			send_op(wallace_pkg::operand_t'($urandom), wallace_pkg::operand_t'($urandom));
		end
		wait_drain();
		assert (out_count - base == 200) else begin
			errors++;
			$display("ERR t=%0t out_valid count expected 200 actual %0d",
				$time, out_count - base);
		end
	endtask

	task automatic output_backpressure();
		int base;
		int prev;
		int t;
		base = out_count;
		auto_credit = 1'b0;
		out_credit = 1'b0;
		for (int i = 0; i < 4; i++) begin
			send_op(wallace_pkg::operand_t'($urandom), wallace_pkg::operand_t'($urandom));
		end
		t = 0;
		while (out_count < base + `WALLACE_OUT_CREDITS && t < TIMEOUT) begin
			@(posedge clk);
			#1;
			t++;
		end
		assert (out_count == base + `WALLACE_OUT_CREDITS) else begin
			errors++;
			$display("t=%0t: first results under back-pressure never arrived", $time);
		end
		repeat (20) begin
			@(negedge clk);
			assert (!out_valid) else begin
				errors++;
				$display("t=%0t: out_valid high with no output credit", $time);
			end
		end
		@(posedge clk);
		#1;
		// one released result per returned credit
		for (int i = 0; i < 4 - `WALLACE_OUT_CREDITS; i++) begin
			prev = out_count;
			return_credit();
			t = 0;
			while (out_count == prev && t < 20) begin
				@(posedge clk);
				#1;
				t++;
			end
			repeat (3) begin
				@(posedge clk);
				#1;
			end
			assert (out_count == prev + 1) else begin
				errors++;
				$display("ERR t=%0t out_valid count expected %0d actual %0d",
					$time, prev + 1, out_count);
			end
		end
		t = 0;
		while (pending > 0 && t < TIMEOUT) begin
			return_credit();
			t++;
		end
		auto_credit = 1'b1;
		wait_drain();
	endtask

	task automatic credit_accounting();
		int base_out;
		int base_pulses;
		base_out = out_count;
		base_pulses = credit_pulses;
		return_pct = 40;
		for (int i = 0; i < 100; i++) begin
			send_op(wallace_pkg::operand_t'($urandom), wallace_pkg::operand_t'($urandom));
		end
		wait_drain();
		return_pct = 100;
		assert (credit_pulses - base_pulses == out_count - base_out) else begin
			errors++;
			$display("ERR t=%0t in_credit pulses expected %0d actual %0d",
				$time, out_count - base_out, credit_pulses - base_pulses);
		end
		assert (out_count - base_out == 100) else begin
			errors++;
			$display("ERR t=%0t out_valid count expected 100 actual %0d",
				$time, out_count - base_out);
		end
		assert (in_credits == `WALLACE_CREDITS) else begin
			errors++;
			$display("ERR t=%0t in_credits expected %0d actual %0d",
				$time, `WALLACE_CREDITS, in_credits);
		end
	endtask

	initial begin
		void'($urandom(32'h332c));
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		out_credit = 1'b0;
		errors = 0;
		in_credits = `WALLACE_CREDITS;
		pending = 0;
		out_count = 0;
		credit_pulses = 0;
		return_pct = 100;
		auto_credit = 1'b1;
		check_reset();
		corner_products();
		random_stream();
		output_backpressure();
		credit_accounting();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
